/* src.f */
svm_geom_pkg.sv
svm_op_pkg.sv
svm_coef_ram.sv
svm_ctrl.sv
svm_pe.sv
svm_row_buf.sv
svm_array.sv
svm_top.sv
tb_svm.sv

/* run_sim.sh */
#!/bin/sh
# build and run the SVM classifier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_svm -f src.f -o tb_svm
./obj_dir/tb_svm > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

/* tb_svm.sv */
// testbench for svm_top: stimulus, reference window sums and result checker
`timescale 1ns/1ns
`default_nettype none

module tb_svm
    import svm_geom_pkg::*;
();

    localparam int CLK_HALF   = 2;
    localparam int RST_CYCLES = 16;
    localparam int WAIT_LIMIT = 300;
    localparam int SEED       = 32'h79e6c688;
    // features within +-2.0, coefficients within +-0.25
    localparam int FEA_SPAN   = 512;
    localparam int COEF_SPAN  = 64;
    localparam int N_WIN_X    = IMG_W - WIN_COL + 1;

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] addr_a;
    logic              we_a;
    logic [RAM_DW-1:0] wdata_a;
    logic [RAM_DW-1:0] rdata_a;
    logic [FEA_W-1:0]  bias;
    logic              bias_load;
    logic              valid;
    logic [FEA_W-1:0]  fea;
    logic              out_valid;
    logic [SW_W-1:0]   sw_id;
    logic [FEA_W-1:0]  result;
    logic              is_person;

    // model state
    logic [FEA_W-1:0]  frames [2][IMG_H][IMG_W][N_FEA];
    logic [RAM_DW-1:0] coef_words [N_FEA];
    logic [FEA_W-1:0]  bias_val;

    logic [FEA_W-1:0]  exp_sum [$];
    logic              exp_flag [$];
    logic [SW_W-1:0]   exp_id [$];
    logic [FEA_W-1:0]  got_sum [$];
    logic [FEA_W-1:0]  e_sum;
    logic              e_flag;
    logic [SW_W-1:0]   e_id;

    string test_name;
    int    errors;
    int    win_seen;
    int    win_expected;
    int    seen_person;
    int    seen_other;
    int    test_pass;
    int    test_fail;

    svm_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .i_addr_a    (addr_a),
        .i_we_a      (we_a),
        .i_wdata_a   (wdata_a),
        .o_rdata_a   (rdata_a),
        .i_bias      (bias),
        .i_bias_load (bias_load),
        .i_valid     (valid),
        .i_fea       (fea),
        .o_valid     (out_valid),
        .o_sw_id     (sw_id),
        .o_result    (result),
        .o_is_person (is_person)
    );

    always #CLK_HALF clk = ~clk;

    // bias plus truncated products of every window cell wrapped to FEA_W bits
    function automatic logic [FEA_W-1:0] window_sum(input int fi, input int wx, input int wy);
        int acc;
        int f_val;
        int c_val;
        acc = int'($signed(bias_val));
        for (int r = 0; r < WIN_ROW; r++) begin
            for (int c = 0; c < WIN_COL; c++) begin
                for (int f = 0; f < N_FEA; f++) begin
                    f_val = int'($signed(frames[fi][wy+r][wx+c][f]));
                    c_val = int'($signed(coef_words[f][(r*WIN_COL+c)*FEA_W +: FEA_W]));
                    acc = acc + ((f_val * c_val) >>> FEA_F);
                end
            end
        end
        return acc[FEA_W-1:0];
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic write_word(input int a, input logic [RAM_DW-1:0] d);
        addr_a  = ADDR_W'(a);
        wdata_a = d;
        we_a    = 1'b1;
        step();
        we_a    = 1'b0;
    endtask

    task automatic load_bias(input logic [FEA_W-1:0] b);
        bias      = b;
        bias_load = 1'b1;
        bias_val  = b;
        step();
        bias_load = 1'b0;
    endtask

    task automatic fill_coefs();
        int v;
        for (int f = 0; f < N_FEA; f++) begin
            for (int i = 0; i < N_COEF; i++) begin
                v = int'($urandom_range(2 * COEF_SPAN, 0)) - COEF_SPAN;
                coef_words[f][i*FEA_W +: FEA_W] = FEA_W'(v);
            end
            write_word(f, coef_words[f]);
        end
    endtask

    task automatic fill_frame(input int fi);
        int v;
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                for (int f = 0; f < N_FEA; f++) begin
                    v = int'($urandom_range(2 * FEA_SPAN - 1, 0)) - FEA_SPAN;
                    frames[fi][y][x][f] = FEA_W'(v);
                end
            end
        end
    endtask

    // windows come out in raster order of their bottom-right cell
    task automatic queue_frame(input int fi);
        logic [FEA_W-1:0] s;
        for (int wy = 0; wy <= IMG_H - WIN_ROW; wy++) begin
            for (int wx = 0; wx < N_WIN_X; wx++) begin
                s = window_sum(fi, wx, wy);
                exp_sum.push_back(s);
                exp_flag.push_back(~s[FEA_W-1]);
                exp_id.push_back(SW_W'(wy * N_WIN_X + wx));
                win_expected++;
            end
        end
    endtask

    task automatic send_frame(input int fi, input bit gaps);
        int idle;
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                for (int f = 0; f < N_FEA; f++) begin
                    idle = gaps ? int'($urandom_range(2, 0)) : 0;
                    repeat (idle) begin
                        // junk on the bus must not disturb the sums
                        valid = 1'b0;
                        fea   = FEA_W'($urandom);
                        step();
                    end
                    valid = 1'b1;
                    fea   = frames[fi][y][x][f];
                    step();
                end
            end
        end
        valid = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        errors       = 0;
        win_seen     = 0;
        win_expected = 0;
        seen_person  = 0;
        seen_other   = 0;
        got_sum.delete();
    endtask

    task automatic end_test();
        if (win_seen != win_expected) begin
            $display("error: test %s window count expected %0d actual %0d",
                     test_name, win_expected, win_seen);
            errors++;
        end
        $display("test %s: %0d windows, %0d errors, %s",
                 test_name, win_seen, errors, (errors == 0) ? "pass" : "fail");
        if (errors == 0) begin
            test_pass++;
        end else begin
            test_fail++;
        end
    endtask

    task automatic finish_run();
        $display("tests passed: %0d, tests failed: %0d", test_pass, test_fail);
        if (test_fail == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic wait_windows();
        int cycles;
        cycles = 0;
        while (exp_sum.size() != 0 && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (exp_sum.size() != 0) begin
            $display("test %s timed out with %0d windows still missing after %0d cycles",
                     test_name, exp_sum.size(), WAIT_LIMIT);
            test_fail++;
            finish_run();
        end else begin
            // idle cycles to catch a stray strobe
            repeat (8) step();
        end
    endtask

    // checker samples away from the rising edge
    always @(negedge clk) begin
        if (rst && out_valid) begin
            win_seen++;
            got_sum.push_back(result);
            if (is_person) begin
                seen_person++;
            end else begin
                seen_other++;
            end
            if (exp_sum.size() == 0) begin
                $display("test %s saw a window strobe that no window explains", test_name);
                errors++;
            end else begin
                e_sum  = exp_sum.pop_front();
                e_flag = exp_flag.pop_front();
                e_id   = exp_id.pop_front();
                if (result !== e_sum) begin
                    $display("error: test %s sum expected %h actual %h", test_name, e_sum, result);
                    errors++;
                end
                if (is_person !== e_flag) begin
                    $display("error: test %s flag expected %b actual %b",
                             test_name, e_flag, is_person);
                    errors++;
                end
                if (sw_id !== e_id) begin
                    $display("error: test %s id expected %0d actual %0d", test_name, e_id, sw_id);
                    errors++;
                end
            end
        end
    end

    initial begin : main_seq
        logic [RAM_DW-1:0] words [N_FEA];
        logic [FEA_W-1:0]  delta;
        void'($urandom(SEED));
        clk       = 1'b0;
        rst       = 1'b0;
        addr_a    = '0;
        we_a      = 1'b0;
        wdata_a   = '0;
        bias      = '0;
        bias_load = 1'b0;
        valid     = 1'b0;
        fea       = '0;
        bias_val  = '0;
        test_pass = 0;
        test_fail = 0;
        begin_test("idle");
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;

        begin_test("ram_rw");
        for (int a = 0; a < N_FEA; a++) begin
            words[a] = RAM_DW'({$urandom, $urandom, $urandom});
            write_word(a, words[a]);
        end
        for (int a = 0; a < N_FEA; a++) begin
            addr_a = ADDR_W'(a);
            step();
            if (rdata_a !== words[a]) begin
                $display("error: test %s word %0d expected %h actual %h",
                         test_name, a, words[a], rdata_a);
                errors++;
            end
        end
        end_test();

        begin_test("frame");
        fill_coefs();
        load_bias(FEA_W'(int'($urandom_range(512, 0)) - 256));
        fill_frame(0);
        queue_frame(0);
        send_frame(0, 1'b0);
        wait_windows();
        end_test();

        begin_test("gaps");
        queue_frame(0);
        send_frame(0, 1'b1);
        wait_windows();
        end_test();

        begin_test("back_to_back");
        fill_frame(1);
        queue_frame(0);
        queue_frame(1);
        send_frame(0, 1'b0);
        send_frame(1, 1'b0);
        wait_windows();
        end_test();

        // +3.0 then -3.0 pushes the sums to both signs
        begin_test("bias_reload");
        load_bias(FEA_W'(768));
        queue_frame(1);
        send_frame(1, 1'b1);
        wait_windows();
        load_bias(FEA_W'(-768));
        delta = FEA_W'(-1536);
        queue_frame(1);
        send_frame(1, 1'b0);
        wait_windows();
        if (got_sum.size() == 2 * N_WIN) begin
            for (int i = 0; i < N_WIN; i++) begin
                if (got_sum[i+N_WIN] !== FEA_W'(got_sum[i] + delta)) begin
                    $display("error: test %s shift of window %0d expected %h actual %h",
                             test_name, i, FEA_W'(got_sum[i] + delta), got_sum[i+N_WIN]);
                    errors++;
                end
            end
        end
        if (seen_person == 0 || seen_other == 0) begin
            $display("test %s did not see both values of the person flag", test_name);
            errors++;
        end
        end_test();

        finish_run();
    end

endmodule

`default_nettype wire

/* svm_top.sv */
// top level: coefficient RAM, controller and element array
`timescale 1ns/1ns
`default_nettype none

module svm_top
    import svm_geom_pkg::*, svm_op_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,

    // coefficient RAM host port
    input  wire logic [ADDR_W-1:0]  i_addr_a,
    input  wire logic               i_we_a,
    input  wire logic [RAM_DW-1:0]  i_wdata_a,
    output logic      [RAM_DW-1:0]  o_rdata_a,

    // bias
    input  wire logic [FEA_W-1:0]   i_bias,
    input  wire logic               i_bias_load,

    // feature stream
    input  wire logic               i_valid,
    input  wire logic [FEA_W-1:0]   i_fea,

    // window results
    output logic                    o_valid,
    output logic [SW_W-1:0]         o_sw_id,
    output logic [FEA_W-1:0]        o_result,
    output logic                    o_is_person
);

    logic [ADDR_W-1:0] addr_b;
    logic [RAM_DW-1:0] coef_word;
    pe_op_t            op;
    logic              buf_shift;

    svm_coef_ram u_coef_ram (
        .clk       (clk),
        .i_addr_a  (i_addr_a),
        .i_we_a    (i_we_a),
        .i_wdata_a (i_wdata_a),
        .o_rdata_a (o_rdata_a),
        .i_addr_b  (addr_b),
        .o_rdata_b (coef_word)
    );

    svm_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .i_valid     (i_valid),
        .o_addr_b    (addr_b),
        .o_op        (op),
        .o_buf_shift (buf_shift),
        .o_valid     (o_valid),
        .o_sw_id     (o_sw_id)
    );

    svm_array u_array (
        .clk         (clk),
        .rst         (rst),
        .i_bias      (i_bias),
        .i_bias_load (i_bias_load),
        .i_fea       (i_fea),
        .i_coef_word (coef_word),
        .i_op        (op),
        .i_buf_shift (buf_shift),
        .o_result    (o_result),
        .o_is_person (o_is_person)
    );

endmodule

`default_nettype wire

/* svm_array.sv */
// systolic element grid with bias register, feature stage and row buffers
`timescale 1ns/1ns
`default_nettype none

module svm_array
    import svm_geom_pkg::*, svm_op_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,

    // bias load
    input  wire logic [FEA_W-1:0]   i_bias,
    input  wire logic               i_bias_load,

    // feature and coefficients
    input  wire logic [FEA_W-1:0]   i_fea,
    input  wire logic [RAM_DW-1:0]  i_coef_word,

    // control from the controller
    input  wire pe_op_t             i_op,
    input  wire logic               i_buf_shift,

    // classification result
    output logic      [FEA_W-1:0]   o_result,
    output logic                    o_is_person
);

    logic [FEA_W-1:0] bias_r;
    logic [FEA_W-1:0] fea_r;

    logic [FEA_W-1:0] coef   [N_COEF];
    logic [FEA_W-1:0] pe_in  [N_COEF];
    logic [FEA_W-1:0] pe_sum [N_COEF];
    logic [FEA_W-1:0] buf_out[WIN_ROW-1];

    always_ff @(posedge clk) begin
        if (!rst) begin
            bias_r <= '0;
        end else if (i_bias_load) begin
            bias_r <= i_bias;
        end
    end

    // feature waits one cycle for the RAM read data
    always_ff @(posedge clk) begin
        fea_r <= i_fea;
    end

    genvar r, c;
    generate
        for (r = 0; r < WIN_ROW; r++) begin : g_row
            for (c = 0; c < WIN_COL; c++) begin : g_col
                localparam int IDX = r * WIN_COL + c;

                assign coef[IDX] = i_coef_word[IDX*FEA_W +: FEA_W];

                // row start takes the bias or the buffered sum of the row above
                if (c == 0 && r == 0) begin : g_bias
                    assign pe_in[IDX] = bias_r;
                end else if (c == 0) begin : g_buf
                    assign pe_in[IDX] = buf_out[r-1];
                end else begin : g_chain
                    assign pe_in[IDX] = pe_sum[IDX-1];
                end

                svm_pe u_pe (
                    .clk    (clk),
                    .rst    (rst),
                    .i_op   (i_op),
                    .i_fea  (fea_r),
                    .i_coef (coef[IDX]),
                    .i_data (pe_in[IDX]),
                    .o_data (pe_sum[IDX])
                );
            end
        end

        // row-end sums of all but the last row
        for (r = 0; r < WIN_ROW - 1; r++) begin : g_buf_row
            svm_row_buf u_row_buf (
                .clk     (clk),
                .rst     (rst),
                .i_shift (i_buf_shift),
                .i_data  (pe_sum[r*WIN_COL + WIN_COL - 1]),
                .o_data  (buf_out[r])
            );
        end
    endgenerate

    // negative sum means no person
    assign o_result    = pe_sum[N_COEF-1];
    assign o_is_person = ~pe_sum[N_COEF-1][FEA_W-1];

endmodule

`default_nettype wire

/* svm_row_buf.sv */
// delay line carrying row-end partial sums to the next window row
`timescale 1ns/1ns
`default_nettype none

module svm_row_buf
    import svm_geom_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    // one shift per cell
    input  wire logic              i_shift,
    input  wire logic [FEA_W-1:0]  i_data,
    output logic      [FEA_W-1:0]  o_data
);

    logic [FEA_W-1:0] stage [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < BUF_DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else if (i_shift) begin
            stage[0] <= i_data;
            for (int i = 1; i < BUF_DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // oldest sum is read by the next row on the same shift
    assign o_data = stage[BUF_DEPTH-1];

endmodule

`default_nettype wire

/* svm_pe.sv */
// multiply-accumulate element with truncated fixed-point product
`timescale 1ns/1ns
`default_nettype none

module svm_pe
    import svm_geom_pkg::*, svm_op_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire pe_op_t            i_op,
    input  wire logic [FEA_W-1:0]  i_fea,
    input  wire logic [FEA_W-1:0]  i_coef,
    // upstream partial sum
    input  wire logic [FEA_W-1:0]  i_data,
    output logic      [FEA_W-1:0]  o_data
);

    logic signed [2*FEA_W-1:0] prod;
    logic        [FEA_W-1:0]   prod_t;

    // full width signed product
    assign prod = $signed(i_fea) * $signed(i_coef);

    // arithmetic shift by FEA_F keeping the low FEA_W bits
    assign prod_t = prod[FEA_F +: FEA_W];

    // sums wrap modulo 2^FEA_W
    always_ff @(posedge clk) begin
        if (!rst) begin
            o_data <= '0;
        end else begin
            case (i_op)
                PE_INIT: o_data <= i_data + prod_t;
                PE_ACC:  o_data <= o_data + prod_t;
                default: o_data <= o_data;
            endcase
        end
    end

endmodule

`default_nettype wire

/* svm_ctrl.sv */
// stream controller: feature, column and row counters, opcodes and window strobe
`timescale 1ns/1ns
`default_nettype none

module svm_ctrl
    import svm_geom_pkg::*, svm_op_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              i_valid,

    // coefficient fetch address
    output logic [ADDR_W-1:0]      o_addr_b,

    // array control
    output pe_op_t                 o_op,
    output logic                   o_buf_shift,

    // window strobe and index
    output logic                   o_valid,
    output logic [SW_W-1:0]        o_sw_id
);

    logic [ADDR_W-1:0] fea_cnt;
    logic [COL_W-1:0]  col_cnt;
    logic [ROW_W-1:0]  row_cnt;

    logic last_fea;
    logic last_col;
    logic last_row;
    logic win_done;
    logic win_p1;

    assign last_fea = (fea_cnt == ADDR_W'(N_FEA - 1));
    assign last_col = (col_cnt == COL_W'(IMG_W - 1));
    assign last_row = (row_cnt == ROW_W'(IMG_H - 1));

    // bottom-right cell of a window that lies fully inside the frame
    assign win_done = i_valid && last_fea
                   && (col_cnt >= COL_W'(WIN_COL - 1))
                   && (row_cnt >= ROW_W'(WIN_ROW - 1));

    // RAM read starts in the same cycle as the feature
    assign o_addr_b = fea_cnt;

    // position in the frame
    always_ff @(posedge clk) begin
        if (!rst) begin
            fea_cnt <= '0;
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_valid) begin
            fea_cnt <= last_fea ? '0 : fea_cnt + 1'b1;
            if (last_fea) begin
                col_cnt <= last_col ? '0 : col_cnt + 1'b1;
                if (last_col) begin
                    row_cnt <= last_row ? '0 : row_cnt + 1'b1;
                end
            end
        end
    end

    // opcode and buffer shift line up with the registered feature
    always_ff @(posedge clk) begin
        if (!rst) begin
            o_op        <= PE_HOLD;
            o_buf_shift <= 1'b0;
        end else begin
            if (!i_valid) begin
                o_op <= PE_HOLD;
            end else if (fea_cnt == '0) begin
                o_op <= PE_INIT;
            end else begin
                o_op <= PE_ACC;
            end
            o_buf_shift <= i_valid && (fea_cnt == '0);
        end
    end

    // second stage matches the accumulator update of the last feature
    always_ff @(posedge clk) begin
        if (!rst) begin
            win_p1  <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            win_p1  <= win_done;
            o_valid <= win_p1;
        end
    end

    // window index steps after each emitted window, wraps at frame end
    always_ff @(posedge clk) begin
        if (!rst) begin
            o_sw_id <= '0;
        end else if (o_valid) begin
            o_sw_id <= (o_sw_id == SW_W'(N_WIN - 1)) ? '0 : o_sw_id + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* svm_coef_ram.sv */
// dual-port coefficient RAM, host read/write on port a, read-only port b
`timescale 1ns/1ns
`default_nettype none

module svm_coef_ram
    import svm_geom_pkg::*;
(
    input  wire logic                clk,

    // host port
    input  wire logic [ADDR_W-1:0]   i_addr_a,
    input  wire logic                i_we_a,
    input  wire logic [RAM_DW-1:0]   i_wdata_a,
    output logic      [RAM_DW-1:0]   o_rdata_a,

    // coefficient fetch port
    input  wire logic [ADDR_W-1:0]   i_addr_b,
    output logic      [RAM_DW-1:0]   o_rdata_b
);

    // one word per feature index, all window coefficients side by side
    logic [RAM_DW-1:0] mem [N_FEA];

    // port a returns the old data on a write cycle
    always_ff @(posedge clk) begin
        if (i_we_a) begin
            mem[i_addr_a] <= i_wdata_a;
        end
        o_rdata_a <= mem[i_addr_a];
    end

    // port b
    always_ff @(posedge clk) begin
        o_rdata_b <= mem[i_addr_b];
    end

endmodule

`default_nettype wire

/* svm_op_pkg.sv */
// opcode type sent from the controller to the array elements
`default_nettype none

package svm_op_pkg;

    // PE_INIT starts a cell from the upstream sum
    // PE_ACC keeps adding into the own sum
    typedef enum logic [1:0] {
        PE_HOLD = 2'd0,
        PE_INIT = 2'd1,
        PE_ACC  = 2'd2
    } pe_op_t;

endpackage

`default_nettype wire

/* svm_geom_pkg.sv */
// frame, window, fixed-point and coefficient RAM geometry constants
`default_nettype none

package svm_geom_pkg;

    // fixed point format of features and coefficients
    localparam int FEA_I = 4;
    localparam int FEA_F = 8;
    localparam int FEA_W = FEA_I + FEA_F;

    // features per cell, one RAM word each
    localparam int N_FEA  = 4;
    localparam int ADDR_W = 2;

    // window size in cells
    localparam int WIN_ROW = 3;
    localparam int WIN_COL = 2;
    localparam int N_COEF  = WIN_ROW * WIN_COL;
    localparam int RAM_DW  = N_COEF * FEA_W;

    // frame size in cells
    localparam int IMG_W = 6;
    localparam int IMG_H = 4;
    localparam int COL_W = $clog2(IMG_W);
    localparam int ROW_W = $clog2(IMG_H);

    // row-end sums wait this many cells for the next window row
    localparam int BUF_DEPTH = IMG_W - WIN_COL;

    // windows per frame and width of the window index
    localparam int N_WIN = (IMG_W - WIN_COL + 1) * (IMG_H - WIN_ROW + 1);
    localparam int SW_W  = 4;

endpackage

`default_nettype wire
